//--- pad_port_pkg.sv
// Shared constants for the joypad port core.
// The RTL and the testbench reach these through pad_port_pkg:: names.
// Pad button fields are packed into one flat vector, pad 0 lowest.

package pad_port_pkg;

	// Multitap geometry
	localparam int PAD_COUNT     = 5;
	localparam int PAD_BITS      = 12;
	localparam int PORT_IDX_BITS = 3;

	// Console side data widths
	localparam int NIBBLE_BITS    = 4;
	localparam int PORT_WORD_BITS = 16;

	// Returned past the last tap port, low nibble reads as nothing pressed
	localparam logic [PORT_WORD_BITS-1:0] IDLE_PORT_WORD = 16'h000F;

	// Cycles of clear held low before the mouse nibble count resyncs
	localparam int MOUSE_TIMEOUT_DEFAULT = 32767;

	////////////////////////////////////////////////////////////////////////////
	// Button layout inside one PAD_BITS field (active high on the host side)
	//   0 right   1 left    2 down    3 up
	//   4 I       5 II      6 select  7 run
	//   8 III     9 IV     10 V      11 VI
	////////////////////////////////////////////////////////////////////////////
	localparam int BTN_RUN    = 7;
	localparam int BTN_SELECT = 6;

endpackage

//--- tap_scanner.sv
// Console side of the joypad port.
// Finds select and clear edges, steps the multitap port index, keeps the
// six-button phase and latches the addressed nibble of port_word.
// port_data follows a strobe change within two clk_sys cycles.

module tap_scanner (
	input  logic                                     clk_sys,
	input  logic                                     reset,
	input  logic                                     port_sel,
	input  logic                                     port_clr,
	input  logic                                     cfg_multitap,
	input  logic                                     cfg_six_button,
	input  logic [pad_port_pkg::PORT_WORD_BITS-1:0]  port_word,
	output logic [pad_port_pkg::PORT_IDX_BITS-1:0]   port_idx,
	output logic                                     clr_rise,
	output logic [pad_port_pkg::NIBBLE_BITS-1:0]     port_data
);

	localparam int IDX_W = pad_port_pkg::PORT_IDX_BITS;
	localparam int NIB_W = pad_port_pkg::NIBBLE_BITS;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(pad_port_pkg::PAD_COUNT);

	logic       sel_q;
	logic       clr_q;
	logic       sel_edge;
	logic       clr_edge;
	logic       phase;
	logic [1:0] nib_sel;

	assign sel_edge = port_sel & ~sel_q;
	assign clr_edge = port_clr & ~clr_q;

	// Nibble number is 2*phase + select
	assign nib_sel = {phase, port_sel};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sel_q     <= 1'b0;
			clr_q     <= 1'b0;
			clr_rise  <= 1'b0;
			port_idx  <= '0;
			phase     <= 1'b0;
			port_data <= '0;
		end else begin
			sel_q    <= port_sel;
			clr_q    <= port_clr;
			clr_rise <= clr_edge;

			if (!cfg_six_button)
				phase <= 1'b0;
			else if (clr_edge)
				phase <= ~phase;

			if (port_clr) begin
				port_idx  <= '0;
				port_data <= '0;
			end else begin
				port_data <= port_word[nib_sel*NIB_W +: NIB_W];
				// Index stops on the idle slot past the last pad
				if (sel_edge && cfg_multitap && port_idx != LAST_IDX)
					port_idx <= port_idx + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Select may keep toggling, index never runs past the idle slot
	a_idx_bound: assert property (@(posedge clk_sys) disable iff (reset)
		port_idx <= LAST_IDX);

	// Single pad mode never leaves port 0
	a_idx_single: assert property (@(posedge clk_sys) disable iff (reset)
		(!cfg_multitap && port_idx == '0) |=> port_idx == '0);

endmodule

//--- pad_formatter.sv
// Builds the 16-bit active-low word for the port addressed by port_idx.
// Nibble 0 is up/right/down/left, nibble 1 run/select/II/I, nibble 2 is
// VI..III and nibble 3 is the six-button identifier 0000.
// Port 0 carries the mouse word instead when cfg_mouse is set.
// Purely combinational.

module pad_formatter (
	input  logic [pad_port_pkg::PORT_IDX_BITS-1:0]                    port_idx,
	input  logic [pad_port_pkg::PAD_COUNT*pad_port_pkg::PAD_BITS-1:0] pad_buttons,
	input  logic [pad_port_pkg::NIBBLE_BITS-1:0]                      mouse_nibble,
	input  logic [1:0]                                                mouse_buttons,
	input  logic                                                      cfg_mouse,
	output logic [pad_port_pkg::PORT_WORD_BITS-1:0]                   port_word
);

	localparam int PAD_W = pad_port_pkg::PAD_BITS;
	localparam int IDX_W = pad_port_pkg::PORT_IDX_BITS;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(pad_port_pkg::PAD_COUNT);

	logic [PAD_W-1:0] pad0;
	logic [PAD_W-1:0] pad;
	logic [7:0]       mouse_byte;

	assign pad0 = pad_buttons[PAD_W-1:0];

	// Motion nibble on top, run/select and the two mouse buttons below
	assign mouse_byte = {mouse_nibble,
		~{pad0[pad_port_pkg::BTN_RUN], pad0[pad_port_pkg::BTN_SELECT],
		  mouse_buttons[0], mouse_buttons[1]}};

	always_comb begin
		pad = '0;
		if (port_idx < LAST_IDX)
			pad = pad_buttons[port_idx*PAD_W +: PAD_W];

		if (port_idx >= LAST_IDX) begin
			port_word = pad_port_pkg::IDLE_PORT_WORD;
		end else if (cfg_mouse && port_idx == '0) begin
			// Same byte in both halves so either phase reads the mouse
			port_word = {mouse_byte, mouse_byte};
		end else begin
			port_word = {4'h0,
				~pad[11:8],
				~pad[7:4],
				~{pad[3], pad[0], pad[2], pad[1]}};
		end
	end

endmodule

//--- mouse_reporter.sv
// Mouse motion reporter for port 0.
// Each toggle of mouse_strobe stores a pending sample (X negated). Every
// clear rise advances the nibble count, and after the fourth nibble the
// pending sample becomes the shown report. If clear stays low for
// mouse_timeout cycles the count is pushed to 3 so the next report starts
// at X high.
// mouse_nibble follows clr_rise by one cycle.

module mouse_reporter #(
	parameter int mouse_timeout = pad_port_pkg::MOUSE_TIMEOUT_DEFAULT
) (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 clr_rise,
	input  logic                                 port_clr,
	input  logic signed [7:0]                    mouse_dx,
	input  logic signed [7:0]                    mouse_dy,
	input  logic                                 mouse_strobe,
	output logic [pad_port_pkg::NIBBLE_BITS-1:0] mouse_nibble
);

	localparam int TO_BITS = $clog2(mouse_timeout + 1);
	localparam logic [TO_BITS-1:0] TO_LIMIT = TO_BITS'(mouse_timeout);

	logic               strobe_q;
	logic [7:0]         pend_x;
	logic [7:0]         pend_y;
	logic [7:0]         shown_x;
	logic [7:0]         shown_y;
	logic [1:0]         count;
	logic [TO_BITS-1:0] idle_cnt;
	logic               idle_full;

	assign idle_full = (idle_cnt == TO_LIMIT);

	// Clear idle timer, saturating
	always_ff @(posedge clk_sys) begin
		if (reset || port_clr)
			idle_cnt <= '0;
		else if (!idle_full)
			idle_cnt <= idle_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Nibble count and report capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			strobe_q <= mouse_strobe;
			pend_x   <= '0;
			pend_y   <= '0;
			shown_x  <= '0;
			shown_y  <= '0;
			count    <= 2'd3;
		end else begin
			strobe_q <= mouse_strobe;

			if (idle_full)
				count <= 2'd3;
			if (clr_rise) begin
				count <= count + 2'd1;
				// Last nibble sent, publish the next report
				if (count == 2'd3) begin
					shown_x <= pend_x;
					shown_y <= pend_y;
					pend_x  <= '0;
					pend_y  <= '0;
				end
			end

			// A new sample wins over the clear of the pending values
			if (strobe_q ^ mouse_strobe) begin
				pend_x <= -mouse_dx;
				pend_y <= mouse_dy;
			end
		end
	end

	always_comb begin
		case (count)
			2'd0:    mouse_nibble = shown_x[7:4];
			2'd1:    mouse_nibble = shown_x[3:0];
			2'd2:    mouse_nibble = shown_y[7:4];
			default: mouse_nibble = shown_y[3:0];
		endcase
	end

	// Long idle clear always lands on the last nibble
	a_resync: assert property (@(posedge clk_sys) disable iff (reset)
		idle_full |=> count == 2'd3);

endmodule

//--- pad_port_top.sv
// Joypad port of the console core.
// The console strobes port_sel and port_clr and reads a 4-bit active-low
// nibble back on port_data. Single pads, six-button pads, the five-port
// multitap and a mouse on port 0 are served from host-side pad state.
// Set mouse_timeout to the idle clear time, in clk_sys cycles, after which
// the mouse report restarts at X high.

module pad_port_top #(
	parameter int mouse_timeout = pad_port_pkg::MOUSE_TIMEOUT_DEFAULT
) (
	input  logic                                                  clk_sys,
	input  logic                                                  reset,

	// Console strobes
	input  logic                                                  port_sel,
	input  logic                                                  port_clr,
	output logic [pad_port_pkg::NIBBLE_BITS-1:0]                  port_data,

	// Host side pad and mouse state
	input  logic [pad_port_pkg::PAD_COUNT*pad_port_pkg::PAD_BITS-1:0] pad_buttons,
	input  logic signed [7:0]                                     mouse_dx,
	input  logic signed [7:0]                                     mouse_dy,
	input  logic [1:0]                                            mouse_buttons,
	input  logic                                                  mouse_strobe,

	// Options
	input  logic                                                  cfg_multitap,
	input  logic                                                  cfg_six_button,
	input  logic                                                  cfg_mouse
);

	logic [pad_port_pkg::PORT_IDX_BITS-1:0]  port_idx;
	logic [pad_port_pkg::PORT_WORD_BITS-1:0] port_word;
	logic [pad_port_pkg::NIBBLE_BITS-1:0]    mouse_nibble;
	logic                                    clr_rise;

	tap_scanner u_tap_scanner (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.port_sel       (port_sel),
		.port_clr       (port_clr),
		.cfg_multitap   (cfg_multitap),
		.cfg_six_button (cfg_six_button),
		.port_word      (port_word),
		.port_idx       (port_idx),
		.clr_rise       (clr_rise),
		.port_data      (port_data)
	);

	pad_formatter u_pad_formatter (
		.port_idx      (port_idx),
		.pad_buttons   (pad_buttons),
		.mouse_nibble  (mouse_nibble),
		.mouse_buttons (mouse_buttons),
		.cfg_mouse     (cfg_mouse),
		.port_word     (port_word)
	);

	mouse_reporter #(
		.mouse_timeout (mouse_timeout)
	) u_mouse_reporter (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.clr_rise     (clr_rise),
		.port_clr     (port_clr),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_strobe (mouse_strobe),
		.mouse_nibble (mouse_nibble)
	);

endmodule

//--- tb_pad_port.sv
// Testbench for the joypad port core.
// Drives port_sel and port_clr on the falling clock edge through single pad,
// six-button, multitap, mouse and mouse resync sequences. A step-level model
// of the port rules gives the expected nibble, and a concurrent check
// compares port_data with it two cycles after every step.

module tb_pad_port;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MOUSE_TO = 64;
	localparam int HOLD     = 3;
	localparam int WATCHDOG = 20000;
	localparam int PADS     = pad_port_pkg::PAD_COUNT;
	localparam int PAD_W    = pad_port_pkg::PAD_BITS;

	logic                    clk_sys;
	logic                    reset;
	logic                    port_sel;
	logic                    port_clr;
	logic [3:0]              port_data;
	logic [PADS*PAD_W-1:0]   pad_buttons;
	logic signed [7:0]       mouse_dx;
	logic signed [7:0]       mouse_dy;
	logic [1:0]              mouse_buttons;
	logic                    mouse_strobe;
	logic                    cfg_multitap;
	logic                    cfg_six_button;
	logic                    cfg_mouse;

	// Model state, updated once per stimulus step
	logic       m_sel;
	logic       m_clr;
	logic       m_strobe;
	logic       m_phase;
	logic [1:0] m_count;
	logic [7:0] m_pend_x;
	logic [7:0] m_pend_y;
	logic [7:0] m_shown_x;
	logic [7:0] m_shown_y;
	int         m_idx;
	int         m_low;
	logic [3:0] exp_nib;
	logic       step_go;

	pad_port_top #(
		.mouse_timeout (MOUSE_TO)
	) dut (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.port_sel       (port_sel),
		.port_clr       (port_clr),
		.port_data      (port_data),
		.pad_buttons    (pad_buttons),
		.mouse_dx       (mouse_dx),
		.mouse_dy       (mouse_dy),
		.mouse_buttons  (mouse_buttons),
		.mouse_strobe   (mouse_strobe),
		.cfg_multitap   (cfg_multitap),
		.cfg_six_button (cfg_six_button),
		.cfg_mouse      (cfg_mouse)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Port data settles two cycles after a step
	a_port_data: assert property (@(posedge clk_sys) disable iff (reset)
		step_go |-> ##2 port_data == exp_nib)
	else begin
		$display("[FAIL] port_data: got %h, expected %h", $sampled(port_data), $sampled(exp_nib));
		$display("sim failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////////////////////
	// Expected port value
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [3:0] expected_nibble();
		logic [15:0]      word;
		logic [PAD_W-1:0] b;
		logic [PAD_W-1:0] b0;
		logic [3:0]       motion;
		logic [7:0]       mbyte;
		logic [1:0]       nib;
		b0 = pad_buttons[PAD_W-1:0];
		case (m_count)
			2'd0:    motion = m_shown_x[7:4];
			2'd1:    motion = m_shown_x[3:0];
			2'd2:    motion = m_shown_y[7:4];
			default: motion = m_shown_y[3:0];
		endcase
		mbyte = {motion, ~{b0[7], b0[6], mouse_buttons[0], mouse_buttons[1]}};
		if (m_idx >= PADS) begin
			word = pad_port_pkg::IDLE_PORT_WORD;
		end else if (cfg_mouse && m_idx == 0) begin
			word = {mbyte, mbyte};
		end else begin
			b = pad_buttons[m_idx*PAD_W +: PAD_W];
			// Identifier, VI..III, run/select/II/I, up/right/down/left
			word = {4'b0000, ~{b[11], b[10], b[9], b[8]}, ~{b[7], b[6], b[5], b[4]},
				~{b[3], b[0], b[2], b[1]}};
		end
		nib = {m_phase, m_sel};
		return word[nib*4 +: 4];
	endfunction

	// Drive new strobe levels, follow them in the model, then hold
	task automatic step(input logic sel, input logic clr, input int hold);
		logic sel_rise;
		logic clr_rise;
		port_sel = sel;
		port_clr = clr;
		sel_rise = sel && !m_sel;
		clr_rise = clr && !m_clr;
		if (mouse_strobe != m_strobe) begin
			m_pend_x = -mouse_dx;
			m_pend_y = mouse_dy;
		end
		m_strobe = mouse_strobe;
		if (clr_rise) begin
			if (m_count == 2'd3) begin
				m_shown_x = m_pend_x;
				m_shown_y = m_pend_y;
				m_pend_x  = '0;
				m_pend_y  = '0;
			end
			m_count = m_count + 2'd1;
		end
		if (!cfg_six_button)
			m_phase = 1'b0;
		else if (clr_rise)
			m_phase = ~m_phase;
		if (clr)
			m_idx = 0;
		else if (sel_rise && cfg_multitap && m_idx < PADS)
			m_idx = m_idx + 1;
		m_sel   = sel;
		m_clr   = clr;
		exp_nib = clr ? 4'h0 : expected_nibble();
		if (clr)
			m_low = 0;
		step_go = 1'b1;
		@(negedge clk_sys);
		step_go = 1'b0;
		for (int i = 1; i < hold; i++)
			@(negedge clk_sys);
		// Long idle clear resyncs the mouse count
		if (!clr) begin
			m_low = m_low + hold;
			if (m_low >= MOUSE_TO)
				m_count = 2'd3;
		end
	endtask

	// One clear pulse, then both select levels
	task automatic read_cycle();
		step(1'b0, 1'b1, HOLD);
		step(1'b0, 1'b0, HOLD);
		step(1'b1, 1'b0, HOLD);
	endtask

	task automatic new_motion();
		mouse_dx     = 8'($urandom);
		mouse_dy     = 8'($urandom);
		mouse_strobe = ~mouse_strobe;
		step(port_sel, port_clr, HOLD);
	endtask

	initial begin
		for (int c = 0; c < WATCHDOG; c++)
			@(posedge clk_sys);
		$display("Timeout: the stimulus did not finish in %0d cycles", WATCHDOG);
		$display("sim failed");
		$fatal(1);
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(16));
		reset          = 1'b1;
		port_sel       = 1'b0;
		port_clr       = 1'b0;
		pad_buttons    = 60'({$urandom, $urandom});
		mouse_dx       = '0;
		mouse_dy       = '0;
		mouse_buttons  = '0;
		mouse_strobe   = 1'b0;
		cfg_multitap   = 1'b0;
		cfg_six_button = 1'b0;
		cfg_mouse      = 1'b0;
		step_go        = 1'b0;
		exp_nib        = '0;
		m_sel          = 1'b0;
		m_clr          = 1'b0;
		m_strobe       = 1'b0;
		m_phase        = 1'b0;
		m_count        = 2'd3;
		m_pend_x       = '0;
		m_pend_y       = '0;
		m_shown_x      = '0;
		m_shown_y      = '0;
		m_idx          = 0;
		m_low          = 0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// Single pad, select rise must not move the index
		step(1'b0, 1'b1, HOLD);
		step(1'b0, 1'b0, HOLD);
		step(1'b1, 1'b0, HOLD);
		step(1'b0, 1'b0, HOLD);
		step(1'b1, 1'b0, HOLD);

		// Six-button phases alternate per clear
		cfg_six_button = 1'b1;
		repeat (4) read_cycle();

		// Multitap walks five pads then the idle slot
		cfg_six_button = 1'b0;
		cfg_multitap   = 1'b1;
		step(1'b0, 1'b1, HOLD);
		step(1'b0, 1'b0, HOLD);
		repeat (PADS + 1) begin
			step(1'b1, 1'b0, HOLD);
			step(1'b0, 1'b0, HOLD);
		end

		// Mouse on port 0, aligned by a long idle clear
		cfg_multitap  = 1'b0;
		cfg_mouse     = 1'b1;
		mouse_buttons = 2'($urandom);
		step(1'b0, 1'b1, HOLD);
		step(1'b0, 1'b0, MOUSE_TO + 16);
		new_motion();
		read_cycle();
		new_motion();
		repeat (3) read_cycle();
		repeat (4) read_cycle();

		// Partial report, then resync restarts at X high
		repeat (2) read_cycle();
		new_motion();
		step(1'b0, 1'b0, MOUSE_TO + 16);
		repeat (4) read_cycle();

		$display("sim passed");
		$finish;
	end

endmodule

//--- filelist.f
pad_port_pkg.sv
tap_scanner.sv
pad_formatter.sv
mouse_reporter.sv
pad_port_top.sv
tb_pad_port.sv

//--- Bender.yml
package:
  name: pad_port

sources:
  # Package first, then the RTL leaves and the top level
  - pad_port_pkg.sv
  - tap_scanner.sv
  - pad_formatter.sv
  - mouse_reporter.sv
  - pad_port_top.sv

  # Testbench
  - target: simulation
    files:
      - tb_pad_port.sv
